// File: rtl/dsp_pkg.sv
`default_nettype none

package dsp_pkg;

    // Word geometry
    localparam int channel_width = 4;
    localparam int code_precision = 8;

    // Equalizer
    localparam int ffe_length = 3;
    localparam int weight_precision = 8;
    localparam int ffe_sum_precision = 18;

    // Channel estimate
    localparam int est_channel_depth = 3;
    localparam int est_channel_precision = 8;
    localparam int shift_precision = 3;
    localparam int error_precision = 12;

    // Buffering between producer and consumer
    localparam int fifo_depth = 4;
    localparam int fifo_ptr_width = $clog2(fifo_depth);
    localparam int fifo_count_width = $clog2(fifo_depth + 1);

    typedef logic signed [code_precision-1:0] code_t;
    typedef code_t [channel_width-1:0] code_word_t;
    typedef logic [channel_width-1:0] bit_word_t;

    typedef logic signed [weight_precision-1:0] weight_t;
    typedef weight_t [ffe_length-1:0] weight_vec_t;
    typedef logic signed [ffe_sum_precision-1:0] ffe_sum_t;

    typedef logic signed [est_channel_precision-1:0] chan_t;
    typedef chan_t [est_channel_depth-1:0] chan_vec_t;
    typedef logic [shift_precision-1:0] shift_t;

    typedef logic signed [error_precision-1:0] error_t;
    typedef error_t [channel_width-1:0] error_word_t;

    typedef logic [fifo_ptr_width-1:0] fifo_ptr_t;
    typedef logic [fifo_count_width-1:0] fifo_count_t;

endpackage : dsp_pkg

`default_nettype wire

// File: rtl/lane_fifo.sv
`timescale 1ns/1ps
`default_nettype none

module lane_fifo #(
    parameter type payload_t = logic
) (
    input  wire logic     clk,
    input  wire logic     rst_n_i,
    input  wire logic     valid_i,
    input  wire payload_t data_i,
    input  wire logic     ready_i,
    output logic          ready_o,
    output logic          valid_o,
    output payload_t      data_o
);
    import dsp_pkg::*;

    payload_t    mem [fifo_depth];
    fifo_ptr_t   wr_ptr;
    fifo_ptr_t   rd_ptr;
    fifo_count_t count;
    logic        push;
    logic        pop;

    function automatic fifo_ptr_t next_ptr(input fifo_ptr_t ptr);
        return (ptr == fifo_ptr_t'(fifo_depth - 1)) ? '0 : ptr + 1'b1;
    endfunction

    // Full FIFO still takes a word when one leaves
    assign ready_o = (count != fifo_count_t'(fifo_depth)) | ready_i;
    assign valid_o = (count != '0);
    assign push    = valid_i & ready_o;
    assign pop     = valid_o & ready_i;
    assign data_o  = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (pop) begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            // Simultaneous push and pop leaves the count alone
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= data_i;
        end
    end

endmodule : lane_fifo

`default_nettype wire

// File: rtl/ffe_slicer.sv
`timescale 1ns/1ps
`default_nettype none

module ffe_slicer (
    input  wire logic                 clk,
    input  wire logic                 rst_n_i,
    input  wire logic                 valid_i,
    input  wire dsp_pkg::code_word_t  codes_i,
    input  wire dsp_pkg::weight_vec_t weights_i,
    input  wire logic                 ready_i,
    output logic                      ready_o,
    output logic                      valid_o,
    output dsp_pkg::bit_word_t        bits_o,
    output dsp_pkg::code_word_t       codes_o
);
    import dsp_pkg::*;

    code_t [channel_width+ffe_length-2:0] window;
    code_t [ffe_length-2:0]               code_hist;
    bit_word_t                            sliced;
    logic                                 accept;

    // Output register is free or drains this cycle
    assign ready_o = ~valid_o | ready_i;
    assign accept  = valid_i & ready_o;

    // Previous word's tail below the new word, lane 0 oldest
    assign window = {codes_i, code_hist};

    always_comb begin
        ffe_sum_t acc;
        for (int i = 0; i < channel_width; i++) begin
            acc = '0;
            for (int k = 0; k < ffe_length; k++) begin
                acc = acc + ffe_sum_t'(window[i+ffe_length-1-k]) * ffe_sum_t'(weights_i[k]);
            end
            // Sign slicer
            sliced[i] = (acc >= 0);
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            valid_o   <= 1'b0;
            code_hist <= '0;
        end else begin
            if (ready_o) begin
                valid_o <= valid_i;
            end
            // Only accepted words advance the history
            if (accept) begin
                code_hist <= codes_i[channel_width-1 -: ffe_length-1];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            bits_o  <= sliced;
            codes_o <= codes_i;
        end
    end

endmodule : ffe_slicer

`default_nettype wire

// File: rtl/channel_error.sv
`timescale 1ns/1ps
`default_nettype none

module channel_error (
    input  wire logic                clk,
    input  wire logic                rst_n_i,
    input  wire logic                valid_i,
    input  wire dsp_pkg::bit_word_t  bits_i,
    input  wire dsp_pkg::code_word_t codes_i,
    input  wire dsp_pkg::chan_vec_t  channel_est_i,
    input  wire dsp_pkg::shift_t     channel_shift_i,
    input  wire logic                ready_i,
    output logic                     ready_o,
    output logic                     valid_o,
    output dsp_pkg::error_word_t     err_o
);
    import dsp_pkg::*;

    logic [channel_width+est_channel_depth-2:0] bit_window;
    logic [est_channel_depth-2:0]               bit_hist;
    error_word_t                                err;
    logic                                       accept;

    assign ready_o = ~valid_o | ready_i;
    assign accept  = valid_i & ready_o;

    // Zero history bits stand for symbol -1
    assign bit_window = {bits_i, bit_hist};

    always_comb begin
        error_t est;
        for (int i = 0; i < channel_width; i++) begin
            est = '0;
            for (int k = 0; k < est_channel_depth; k++) begin
                // Bit 1 is +1, bit 0 is -1
                if (bit_window[i+est_channel_depth-1-k]) begin
                    est = est + error_t'(channel_est_i[k]);
                end else begin
                    est = est - error_t'(channel_est_i[k]);
                end
            end
            est    = est >>> channel_shift_i;
            err[i] = est - error_t'(codes_i[i]);
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            valid_o  <= 1'b0;
            bit_hist <= '0;
        end else begin
            if (ready_o) begin
                valid_o <= valid_i;
            end
            if (accept) begin
                bit_hist <= bits_i[channel_width-1 -: est_channel_depth-1];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            err_o <= err;
        end
    end

endmodule : channel_error

`default_nettype wire

// File: rtl/datapath_core.sv
`timescale 1ns/1ps
`default_nettype none

module datapath_core (
    input  wire logic                 clk,
    input  wire logic                 rst_n_i,
    input  wire logic                 adc_valid_i,
    input  wire dsp_pkg::code_word_t  adc_codes_i,
    input  wire dsp_pkg::weight_vec_t weights_i,
    input  wire dsp_pkg::chan_vec_t   channel_est_i,
    input  wire dsp_pkg::shift_t      channel_shift_i,
    input  wire logic                 err_ready_i,
    output logic                      adc_ready_o,
    output logic                      err_valid_o,
    output dsp_pkg::error_word_t      err_o
);
    import dsp_pkg::*;

    logic       ffe_valid;
    logic       ffe_ready;
    bit_word_t  ffe_bits;
    code_word_t ffe_codes;

    logic       bit_fifo_ready;
    logic       code_fifo_ready;
    logic       fifo_valid;
    bit_word_t  fifo_bits;
    code_word_t fifo_codes;
    logic       err_pop;

    // Both FIFOs move in lockstep
    assign ffe_ready = bit_fifo_ready & code_fifo_ready;

    ffe_slicer ffe_slicer_inst (
        .clk       (clk),
        .rst_n_i   (rst_n_i),
        .valid_i   (adc_valid_i),
        .codes_i   (adc_codes_i),
        .weights_i (weights_i),
        .ready_i   (ffe_ready),
        .ready_o   (adc_ready_o),
        .valid_o   (ffe_valid),
        .bits_o    (ffe_bits),
        .codes_o   (ffe_codes)
    );

    lane_fifo #(
        .payload_t (bit_word_t)
    ) bit_fifo (
        .clk     (clk),
        .rst_n_i (rst_n_i),
        .valid_i (ffe_valid),
        .data_i  (ffe_bits),
        .ready_i (err_pop),
        .ready_o (bit_fifo_ready),
        .valid_o (fifo_valid),
        .data_o  (fifo_bits)
    );

    // Valid tracks bit_fifo since the counts never differ
    lane_fifo #(
        .payload_t (code_word_t)
    ) code_fifo (
        .clk     (clk),
        .rst_n_i (rst_n_i),
        .valid_i (ffe_valid),
        .data_i  (ffe_codes),
        .ready_i (err_pop),
        .ready_o (code_fifo_ready),
        .valid_o (),
        .data_o  (fifo_codes)
    );

    channel_error channel_error_inst (
        .clk             (clk),
        .rst_n_i         (rst_n_i),
        .valid_i         (fifo_valid),
        .bits_i          (fifo_bits),
        .codes_i         (fifo_codes),
        .channel_est_i   (channel_est_i),
        .channel_shift_i (channel_shift_i),
        .ready_i         (err_ready_i),
        .ready_o         (err_pop),
        .valid_o         (err_valid_o),
        .err_o           (err_o)
    );

endmodule : datapath_core

`default_nettype wire

// File: include/datapath_model.svh
`ifndef DATAPATH_MODEL_SVH
`define DATAPATH_MODEL_SVH

// Model history, carried across words like the hardware
int   model_code_hist [dsp_pkg::ffe_length-1];
logic model_bit_hist [dsp_pkg::est_channel_depth-1];

function automatic void model_reset();
    foreach (model_code_hist[j]) begin
        model_code_hist[j] = 0;
    end
    foreach (model_bit_hist[j]) begin
        model_bit_hist[j] = 1'b0;
    end
endfunction

function automatic dsp_pkg::bit_word_t model_slice(input dsp_pkg::code_word_t codes,
                                                   input dsp_pkg::weight_vec_t w);
    int win [dsp_pkg::channel_width + dsp_pkg::ffe_length - 1];
    int acc;
    dsp_pkg::bit_word_t bits;
    foreach (model_code_hist[j]) begin
        win[j] = model_code_hist[j];
    end
    for (int i = 0; i < dsp_pkg::channel_width; i++) begin
        win[i + dsp_pkg::ffe_length - 1] = codes[i];
    end
    for (int i = 0; i < dsp_pkg::channel_width; i++) begin
        acc = 0;
        for (int k = 0; k < dsp_pkg::ffe_length; k++) begin
            acc += win[i + dsp_pkg::ffe_length - 1 - k] * int'(w[k]);
        end
        bits[i] = (acc >= 0);
    end
    foreach (model_code_hist[j]) begin
        model_code_hist[j] = win[dsp_pkg::channel_width + j];
    end
    return bits;
endfunction

function automatic dsp_pkg::error_word_t model_error(input dsp_pkg::bit_word_t bits,
                                                     input dsp_pkg::code_word_t codes,
                                                     input dsp_pkg::chan_vec_t ch,
                                                     input dsp_pkg::shift_t sh);
    logic win [dsp_pkg::channel_width + dsp_pkg::est_channel_depth - 1];
    int est;
    dsp_pkg::error_word_t err;
    foreach (model_bit_hist[j]) begin
        win[j] = model_bit_hist[j];
    end
    for (int i = 0; i < dsp_pkg::channel_width; i++) begin
        win[i + dsp_pkg::est_channel_depth - 1] = bits[i];
    end
    for (int i = 0; i < dsp_pkg::channel_width; i++) begin
        est = 0;
        for (int k = 0; k < dsp_pkg::est_channel_depth; k++) begin
            est += win[i + dsp_pkg::est_channel_depth - 1 - k] ? int'(ch[k]) : -int'(ch[k]);
        end
        est    = est >>> sh;
        err[i] = dsp_pkg::error_t'(est - int'(codes[i]));
    end
    foreach (model_bit_hist[j]) begin
        model_bit_hist[j] = win[dsp_pkg::channel_width + j];
    end
    return err;
endfunction

// One accepted input word through the whole datapath
function automatic dsp_pkg::error_word_t model_step(input dsp_pkg::code_word_t codes,
                                                    input dsp_pkg::weight_vec_t w,
                                                    input dsp_pkg::chan_vec_t ch,
                                                    input dsp_pkg::shift_t sh);
    dsp_pkg::bit_word_t bits;
    bits = model_slice(codes, w);
    return model_error(bits, codes, ch, sh);
endfunction

`endif

// File: bench/datapath_core_tb.sv
`timescale 1ns/1ps
`default_nettype none

module datapath_core_tb;
    import dsp_pkg::*;

    localparam int clk_period = 4;
    localparam int total_words = 706;

    logic        clk = 1'b0;
    logic        rst_n_i;
    logic        adc_valid_i;
    code_word_t  adc_codes_i;
    weight_vec_t weights_i;
    chan_vec_t   channel_est_i;
    shift_t      channel_shift_i;
    logic        err_ready_i;
    logic        adc_ready_o;
    logic        err_valid_o;
    error_word_t err_o;

    int          seed = 9;
    int          ready_mode = 0;
    int          cycle_count = 0;
    int          in_count = 0;
    bit          latency_check = 1'b0;
    error_word_t exp_q[$];
    int          cyc_q[$];

    `include "datapath_model.svh"

    always #(clk_period / 2) clk = ~clk;

    datapath_core datapath_core_inst (.*);

    task automatic end_in_failure();
        $display("SOME TESTS FAILED");
        $fatal(1);
    endtask

    task automatic check_word(input string name, input error_word_t expected,
                              input error_word_t actual);
        if (actual !== expected) begin
            $display("mismatch time=%0t signal=%s expected=%h actual=%h",
                     $time, name, expected, actual);
            end_in_failure();
        end
    endtask

    task automatic check_bit(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            $display("mismatch time=%0t signal=%s expected=%b actual=%b",
                     $time, name, expected, actual);
            end_in_failure();
        end
    endtask

    // Mode 0 keeps err_ready_i high, 1 randomizes it, 2 holds it low
    task automatic next_cycle();
        logic [31:0] r;
        @(negedge clk);
        r = $random(seed);
        err_ready_i = (ready_mode == 0) || (ready_mode == 1 && r[1:0] != 2'b00);
    endtask

    task automatic randomize_config();
        logic [31:0] r;
        r = $random(seed);
        weights_i = weight_vec_t'(r[23:0]);
        r = $random(seed);
        channel_est_i = chan_vec_t'(r[23:0]);
        r = $random(seed);
        channel_shift_i = shift_t'(r[2:0]);
    endtask

    task automatic send_word(input bit gaps);
        logic [31:0] r;
        r = $random(seed);
        if (gaps) begin
            repeat (int'(r[1:0])) next_cycle();
        end
        r = $random(seed);
        adc_valid_i = 1'b1;
        adc_codes_i = code_word_t'(r);
        #1;
        while (!adc_ready_o) begin
            next_cycle();
            #1;
        end
        next_cycle();
        adc_valid_i = 1'b0;
    endtask

    task automatic drain();
        int waited;
        waited = 0;
        while (exp_q.size() != 0 && waited < 100) begin
            next_cycle();
            waited++;
        end
        next_cycle();
        check_bit("err_valid_o", 1'b0, err_valid_o);
        check_bit("adc_ready_o", 1'b1, adc_ready_o);
    endtask

    // Scoreboard on both handshakes
    always @(posedge clk) begin
        error_word_t expected;
        int          in_cycle;
        cycle_count++;
        if (rst_n_i && adc_valid_i && adc_ready_o) begin
            exp_q.push_back(model_step(adc_codes_i, weights_i, channel_est_i, channel_shift_i));
            cyc_q.push_back(cycle_count);
            in_count++;
        end
        if (rst_n_i && err_valid_o && err_ready_i) begin
            if (exp_q.size() == 0) begin
                $display("output word at %0t arrived with nothing expected", $time);
                end_in_failure();
            end else begin
                expected = exp_q.pop_front();
                in_cycle = cyc_q.pop_front();
                check_word("err_o", expected, err_o);
                if (latency_check && cycle_count - in_cycle != 3) begin
                    $display("output latency was %0d cycles instead of 3",
                             cycle_count - in_cycle);
                    end_in_failure();
                end
            end
        end
    end

    initial begin
        int       start;
        logic     acc;
        rst_n_i     = 1'b0;
        adc_valid_i = 1'b0;
        adc_codes_i = '0;
        err_ready_i = 1'b0;
        randomize_config();
        model_reset();
        repeat (10) begin
            @(negedge clk);
            check_bit("err_valid_o", 1'b0, err_valid_o);
            check_bit("adc_ready_o", 1'b1, adc_ready_o);
        end
        rst_n_i = 1'b1;
        next_cycle();
        check_bit("err_valid_o", 1'b0, err_valid_o);
        check_bit("adc_ready_o", 1'b1, adc_ready_o);

        // Full-rate stream with fixed latency
        latency_check = 1'b1;
        repeat (200) send_word(1'b0);
        drain();
        latency_check = 1'b0;

        // Random gaps and back-pressure
        ready_mode = 1;
        repeat (300) send_word(1'b1);
        drain();

        // Output stalled, the core fills up
        ready_mode = 2;
        next_cycle();
        start       = in_count;
        adc_valid_i = 1'b1;
        adc_codes_i = code_word_t'($random(seed));
        repeat (20) begin
            #1;
            acc = adc_ready_o;
            next_cycle();
            if (acc) begin
                adc_codes_i = code_word_t'($random(seed));
            end
        end
        adc_valid_i = 1'b0;
        if (in_count - start != 6) begin
            $display("core accepted %0d words while stalled instead of 6", in_count - start);
            end_in_failure();
        end
        #1;
        check_bit("adc_ready_o", 1'b0, adc_ready_o);
        ready_mode = 0;
        drain();

        // New configuration on an empty datapath
        randomize_config();
        ready_mode = 1;
        repeat (200) send_word(1'b1);
        ready_mode = 0;
        drain();

        if (exp_q.size() != 0) begin
            $display("%0d expected words never came out", exp_q.size());
            end_in_failure();
        end else begin
            $display("ALL TESTS PASSED");
            $finish;
        end
    end

    initial begin
        #(clk_period * (total_words * 8 + 500));
        $display("run timed out before all words were checked");
        end_in_failure();
    end

endmodule : datapath_core_tb

`default_nettype wire

// File: list.f
+incdir+include
rtl/dsp_pkg.sv
rtl/lane_fifo.sv
rtl/ffe_slicer.sv
rtl/channel_error.sv
rtl/datapath_core.sv
bench/datapath_core_tb.sv

// File: run.sh
#!/usr/bin/env bash
# Build and run the datapath_core testbench with Verilator

cd "$(dirname "$0")" && \
verilator --binary --timing --timescale 1ns/1ps -Wno-fatal \
    -f list.f --top-module datapath_core_tb -o datapath_core_sim && \
./obj_dir/datapath_core_sim || { echo "simulation failed"; exit 1; }
